// ==== include/tma_smem_consts.svh ====
// Constants for the TMA shared-memory subsystem
// Engine, socket and core counts, tag field widths and memory geometry
`ifndef TMA_SMEM_CONSTS_SVH
`define TMA_SMEM_CONSTS_SVH

// Cluster population
`define TMA_NUM_UNITS        4
`define TMA_NUM_SOCKETS      2
`define TMA_NUM_CORES        4
// Two cores share one socket
`define TMA_CORE_LOCAL_BITS  1

// Shared memory geometry, word addressed
`define TMA_SMEM_ADDR_WIDTH  8
`define TMA_SMEM_WORD_SIZE   4
`define TMA_SMEM_DEPTH       256

// Tag fields carried with every request
`define TMA_TAG_VALUE_WIDTH  8
`define TMA_TAG_UUID_WIDTH   4

`endif

// ==== hw/tma_route_pkg.sv ====
// Routing types for the TMA shared-memory path
// Engine, socket and core ids, the request tag and tag field helpers
`include "tma_smem_consts.svh"

package tma_route_pkg;

    localparam int ENGINE_ID_W = $clog2(`TMA_NUM_UNITS);
    localparam int SOCKET_ID_W = $clog2(`TMA_NUM_SOCKETS);
    localparam int CORE_ID_W   = $clog2(`TMA_NUM_CORES);

    typedef logic [ENGINE_ID_W-1:0] engine_id_t;
    typedef logic [SOCKET_ID_W-1:0] socket_id_t;
    typedef logic [CORE_ID_W-1:0]   core_id_t;

    // The low value bits hold the engine id, the core id sits just above it
    typedef struct packed {
        logic [`TMA_TAG_UUID_WIDTH-1:0]  uuid;
        logic [`TMA_TAG_VALUE_WIDTH-1:0] value;
    } smem_tag_t;

    function automatic engine_id_t tag_engine(smem_tag_t tag);
        return tag.value[ENGINE_ID_W-1:0];
    endfunction

    function automatic core_id_t tag_core(smem_tag_t tag);
        return tag.value[ENGINE_ID_W +: CORE_ID_W];
    endfunction

    // Cores are grouped per socket, so dropping the local bits gives the socket
    function automatic socket_id_t core_socket(core_id_t core);
        return socket_id_t'(core >> `TMA_CORE_LOCAL_BITS);
    endfunction

endpackage

// ==== hw/tma_smem_pkg.sv ====
// Payload types for the TMA shared-memory path
// Field types plus the request and response structs that travel on each link
`include "tma_smem_consts.svh"

package tma_smem_pkg;

    localparam int SMEM_DATA_W  = `TMA_SMEM_WORD_SIZE * 8;
    localparam int SMEM_FLAGS_W = 2;

    typedef logic [`TMA_SMEM_ADDR_WIDTH-1:0] smem_addr_t;
    typedef logic [SMEM_DATA_W-1:0]          smem_data_t;
    typedef logic [`TMA_SMEM_WORD_SIZE-1:0]  smem_byteen_t;
    typedef logic [SMEM_FLAGS_W-1:0]         smem_flags_t;

    // Request from an engine to a socket memory
    // rw set means write; byteen selects the bytes a write touches
    typedef struct packed {
        logic                     rw;
        smem_addr_t               addr;
        smem_data_t               data;
        smem_byteen_t             byteen;
        smem_flags_t              flags;
        tma_route_pkg::smem_tag_t tag;
    } tma_smem_req_t;

    // Read response, the tag comes back exactly as it was sent
    typedef struct packed {
        smem_data_t               data;
        tma_route_pkg::smem_tag_t tag;
    } tma_smem_rsp_t;

endpackage

// ==== hw/tma_stream_xbar.sv ====
// Valid/ready stream crossbar, N inputs to M outputs
// Per-output round-robin arbiter feeding a two-entry output FIFO
// The payload type is a parameter so one module serves requests and responses
module tma_stream_xbar #(
    parameter int  NUM_INPUTS  = 4,
    parameter int  NUM_OUTPUTS = 2,
    parameter type payload_t   = logic [31:0],
    localparam int SEL_W       = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic [NUM_INPUTS-1:0]            valid_in,
    input  payload_t [NUM_INPUTS-1:0]        data_in,
    input  logic [NUM_INPUTS-1:0][SEL_W-1:0] sel_in,
    output logic [NUM_INPUTS-1:0]            ready_in,

    output logic [NUM_OUTPUTS-1:0]           valid_out,
    output payload_t [NUM_OUTPUTS-1:0]       data_out,
    input  logic [NUM_OUTPUTS-1:0]           ready_out
);

    localparam int IN_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    logic [NUM_OUTPUTS-1:0]                 out_room;
    logic [NUM_OUTPUTS-1:0][NUM_INPUTS-1:0] out_grant;

    for (genvar o = 0; o < NUM_OUTPUTS; o++) begin : g_out
        logic [NUM_INPUTS-1:0] req;
        logic [IN_W-1:0]       rr_ptr;
        logic [IN_W-1:0]       win_idx;
        logic                  win_valid;
        logic                  push;
        logic                  pop;
        payload_t              fifo_mem [2];
        logic                  wr_ptr;
        logic                  rd_ptr;
        logic [1:0]            count;

        for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_req
            assign req[i] = valid_in[i] && (sel_in[i] == SEL_W'(o));
            assign out_grant[o][i] = push && (win_idx == IN_W'(i));
        end

        // Search starts at the pointer and wraps, first requester wins
        always_comb begin
            int idx;
            win_valid = 1'b0;
            win_idx   = '0;
            for (int k = 0; k < NUM_INPUTS; k++) begin
                idx = (int'(rr_ptr) + k) % NUM_INPUTS;
                if (!win_valid && req[idx]) begin
                    win_valid = 1'b1;
                    win_idx   = IN_W'(idx);
                end
            end
        end

        assign out_room[o] = (count != 2'd2);
        assign push        = win_valid && out_room[o];
        assign pop         = valid_out[o] && ready_out[o];

        // Pointer moves just past the winner so it has lowest priority next time
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rr_ptr <= '0;
            end else if (push) begin
                rr_ptr <= (win_idx == IN_W'(NUM_INPUTS - 1)) ? '0 : win_idx + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr <= 1'b0;
                rd_ptr <= 1'b0;
                count  <= 2'd0;
            end else begin
                if (push) begin
                    wr_ptr <= ~wr_ptr;
                end
                if (pop) begin
                    rd_ptr <= ~rd_ptr;
                end
                count <= count + 2'(push) - 2'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                fifo_mem[wr_ptr] <= data_in[win_idx];
            end
        end

        assign valid_out[o] = (count != 2'd0);
        assign data_out[o]  = fifo_mem[rd_ptr];
    end

    // An idle input shows ready when its target has room
    // A waiting input is ready only in the cycle its output grants it
    always_comb begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            ready_in[i] = valid_in[i] ? out_grant[sel_in[i]][i] : out_room[sel_in[i]];
        end
    end

endmodule

// ==== hw/tma_cluster_smem_xbar.sv ====
// Cluster crossbar between the TMA engines and the socket memories
// Request side routes on the core id in the tag, response side on the engine id
// Both directions use the same round-robin stream crossbar
`include "tma_smem_consts.svh"

module tma_cluster_smem_xbar (
    input  logic                                                 clk,
    input  logic                                                 rst_n,

    // Engine side
    input  logic [`TMA_NUM_UNITS-1:0]                            req_valid,
    input  tma_smem_pkg::tma_smem_req_t [`TMA_NUM_UNITS-1:0]     req_data,
    output logic [`TMA_NUM_UNITS-1:0]                            req_ready,
    output logic [`TMA_NUM_UNITS-1:0]                            rsp_valid,
    output tma_smem_pkg::tma_smem_rsp_t [`TMA_NUM_UNITS-1:0]     rsp_data,
    input  logic [`TMA_NUM_UNITS-1:0]                            rsp_ready,

    // Socket side
    output logic [`TMA_NUM_SOCKETS-1:0]                          sock_req_valid,
    output tma_smem_pkg::tma_smem_req_t [`TMA_NUM_SOCKETS-1:0]   sock_req_data,
    input  logic [`TMA_NUM_SOCKETS-1:0]                          sock_req_ready,
    input  logic [`TMA_NUM_SOCKETS-1:0]                          sock_rsp_valid,
    input  tma_smem_pkg::tma_smem_rsp_t [`TMA_NUM_SOCKETS-1:0]   sock_rsp_data,
    output logic [`TMA_NUM_SOCKETS-1:0]                          sock_rsp_ready
);

    import tma_route_pkg::*;
    import tma_smem_pkg::*;

    socket_id_t [`TMA_NUM_UNITS-1:0]   req_sock_sel;
    engine_id_t [`TMA_NUM_SOCKETS-1:0] rsp_engine_sel;

    // Each request goes to the socket that owns its target core
    for (genvar i = 0; i < `TMA_NUM_UNITS; i++) begin : g_req_route
        core_id_t req_core;
        assign req_core        = tag_core(req_data[i].tag);
        assign req_sock_sel[i] = core_socket(req_core);
    end

    // Responses carry the issuing engine in the low tag bits
    for (genvar s = 0; s < `TMA_NUM_SOCKETS; s++) begin : g_rsp_route
        assign rsp_engine_sel[s] = tag_engine(sock_rsp_data[s].tag);
    end

    tma_stream_xbar #(
        .NUM_INPUTS  (`TMA_NUM_UNITS),
        .NUM_OUTPUTS (`TMA_NUM_SOCKETS),
        .payload_t   (tma_smem_req_t)
    ) req_xbar_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (req_valid),
        .data_in   (req_data),
        .sel_in    (req_sock_sel),
        .ready_in  (req_ready),
        .valid_out (sock_req_valid),
        .data_out  (sock_req_data),
        .ready_out (sock_req_ready)
    );

    tma_stream_xbar #(
        .NUM_INPUTS  (`TMA_NUM_SOCKETS),
        .NUM_OUTPUTS (`TMA_NUM_UNITS),
        .payload_t   (tma_smem_rsp_t)
    ) rsp_xbar_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (sock_rsp_valid),
        .data_in   (sock_rsp_data),
        .sel_in    (rsp_engine_sel),
        .ready_in  (sock_rsp_ready),
        .valid_out (rsp_valid),
        .data_out  (rsp_data),
        .ready_out (rsp_ready)
    );

endmodule

// ==== hw/socket_smem.sv ====
// Shared memory of one socket
// Word addressed, byte-enabled writes, one registered read response
// A held response stalls new requests until it drains
`include "tma_smem_consts.svh"

module socket_smem (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        req_valid,
    input  tma_smem_pkg::tma_smem_req_t req_data,
    output logic                        req_ready,

    output logic                        rsp_valid,
    output tma_smem_pkg::tma_smem_rsp_t rsp_data,
    input  logic                        rsp_ready
);

    import tma_smem_pkg::*;

    smem_data_t mem [`TMA_SMEM_DEPTH];

    logic req_fire;
    logic wr_fire;
    logic rd_fire;

    // Accept only when the response slot is empty or empties on this edge
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = req_fire && req_data.rw;
    assign rd_fire   = req_fire && !req_data.rw;

    // Only bytes with their enable set are written
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < `TMA_SMEM_WORD_SIZE; b++) begin
                if (req_data.byteen[b]) begin
                    mem[req_data.addr][b*8 +: 8] <= req_data.data[b*8 +: 8];
                end
            end
        end
    end

    // Read data and tag are captured together
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data.data <= mem[req_data.addr];
            rsp_data.tag  <= req_data.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

endmodule

// ==== hw/tma_smem_subsystem_top.sv ====
// Top level of the TMA shared-memory subsystem
// Cluster crossbar in front of one shared memory per socket
`include "tma_smem_consts.svh"

module tma_smem_subsystem_top (
    input  logic                                             clk,
    input  logic                                             rst_n,

    input  logic [`TMA_NUM_UNITS-1:0]                        req_valid,
    input  tma_smem_pkg::tma_smem_req_t [`TMA_NUM_UNITS-1:0] req_data,
    output logic [`TMA_NUM_UNITS-1:0]                        req_ready,

    output logic [`TMA_NUM_UNITS-1:0]                        rsp_valid,
    output tma_smem_pkg::tma_smem_rsp_t [`TMA_NUM_UNITS-1:0] rsp_data,
    input  logic [`TMA_NUM_UNITS-1:0]                        rsp_ready
);

    import tma_smem_pkg::*;

    logic [`TMA_NUM_SOCKETS-1:0]          sock_req_valid;
    tma_smem_req_t [`TMA_NUM_SOCKETS-1:0] sock_req_data;
    logic [`TMA_NUM_SOCKETS-1:0]          sock_req_ready;
    logic [`TMA_NUM_SOCKETS-1:0]          sock_rsp_valid;
    tma_smem_rsp_t [`TMA_NUM_SOCKETS-1:0] sock_rsp_data;
    logic [`TMA_NUM_SOCKETS-1:0]          sock_rsp_ready;

    tma_cluster_smem_xbar cluster_xbar_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_data       (req_data),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .rsp_ready      (rsp_ready),
        .sock_req_valid (sock_req_valid),
        .sock_req_data  (sock_req_data),
        .sock_req_ready (sock_req_ready),
        .sock_rsp_valid (sock_rsp_valid),
        .sock_rsp_data  (sock_rsp_data),
        .sock_rsp_ready (sock_rsp_ready)
    );

    for (genvar s = 0; s < `TMA_NUM_SOCKETS; s++) begin : g_socket
        socket_smem socket_smem_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .req_valid (sock_req_valid[s]),
            .req_data  (sock_req_data[s]),
            .req_ready (sock_req_ready[s]),
            .rsp_valid (sock_rsp_valid[s]),
            .rsp_data  (sock_rsp_data[s]),
            .rsp_ready (sock_rsp_ready[s])
        );
    end

endmodule

// ==== verification/tma_smem_tb.sv ====
// Testbench for the TMA shared-memory subsystem
// Table of single requests, four-engine read bursts with and without back-pressure,
// a reference memory per socket and typed compare tasks
`include "tma_smem_consts.svh"

module tma_smem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tma_route_pkg::*;
    import tma_smem_pkg::*;

    localparam int         TIMEOUT_CYCLES = 200;
    localparam int         READ_LATENCY   = 3;
    localparam smem_addr_t BURST_ADDR     = 8'h10;

    typedef logic [`TMA_TAG_UUID_WIDTH-1:0] uuid_t;

    typedef struct {
        string        name;
        engine_id_t   engine;
        logic         rw;
        core_id_t     core;
        smem_addr_t   addr;
        smem_data_t   data;
        smem_byteen_t byteen;
        uuid_t        uuid;
    } op_t;

    logic                                clk;
    logic                                rst_n;
    logic [`TMA_NUM_UNITS-1:0]           req_valid;
    tma_smem_req_t [`TMA_NUM_UNITS-1:0]  req_data;
    logic [`TMA_NUM_UNITS-1:0]           req_ready;
    logic [`TMA_NUM_UNITS-1:0]           rsp_valid;
    tma_smem_rsp_t [`TMA_NUM_UNITS-1:0]  rsp_data;
    logic [`TMA_NUM_UNITS-1:0]           rsp_ready;

    // Expected contents of both socket memories
    smem_data_t ref_mem [`TMA_NUM_SOCKETS][`TMA_SMEM_DEPTH];
    op_t        ops [$];

    tma_smem_subsystem_top tma_smem_subsystem_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_data  (req_data),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic op_t make_op(string name, engine_id_t engine, logic rw, core_id_t core,
                                    smem_addr_t addr, smem_data_t data, smem_byteen_t byteen,
                                    uuid_t uuid);
        return op_t'{name, engine, rw, core, addr, data, byteen, uuid};
    endfunction

    // Value field is free bits, then core id, then engine id in the lowest bits
    function automatic smem_tag_t make_tag(engine_id_t engine, core_id_t core, uuid_t uuid);
        smem_tag_t tag;
        tag.uuid  = uuid;
        tag.value = {~uuid, core, engine};
        return tag;
    endfunction

    function automatic engine_id_t engine_field(smem_tag_t tag);
        return tag.value[1:0];
    endfunction

    function automatic int socket_of(core_id_t core);
        return int'(core) >> `TMA_CORE_LOCAL_BITS;
    endfunction

    function automatic tma_smem_req_t make_req(op_t op);
        tma_smem_req_t req;
        req.rw     = op.rw;
        req.addr   = op.addr;
        req.data   = op.data;
        req.byteen = op.byteen;
        req.flags  = '0;
        req.tag    = make_tag(op.engine, op.core, op.uuid);
        return req;
    endfunction

    function automatic void model_write(op_t op);
        int s;
        s = socket_of(op.core);
        for (int b = 0; b < `TMA_SMEM_WORD_SIZE; b++) begin
            if (op.byteen[b]) begin
                ref_mem[s][op.addr][b*8 +: 8] = op.data[b*8 +: 8];
            end
        end
    endfunction

    function automatic tma_smem_rsp_t expected_rsp(op_t op);
        tma_smem_rsp_t rsp;
        rsp.data = ref_mem[socket_of(op.core)][op.addr];
        rsp.tag  = make_tag(op.engine, op.core, op.uuid);
        return rsp;
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_rsp(string name, tma_smem_rsp_t exp, tma_smem_rsp_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected data %h tag %h, actual data %h tag %h",
                                name, exp.data, exp.tag, act.data, act.tag));
        end
    endtask

    task automatic check_engine(string name, engine_id_t exp, engine_id_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected engine %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            abort_run($sformatf("FAIL %s: expected latency %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ports(string name, logic [`TMA_NUM_UNITS-1:0] exp,
                               logic [`TMA_NUM_UNITS-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Holds the request until the engine's req_ready, then drops valid on the transfer edge
    task automatic send_op(op_t op);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk);
        req_valid[op.engine] <= 1'b1;
        req_data[op.engine]  <= make_req(op);
        forever begin
            @(negedge clk);
            if (req_ready[op.engine]) break;
            wait_cycles++;
            if (wait_cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timed out waiting for req_ready of engine %0d in %s",
                                    op.engine, op.name));
            end
        end
        @(posedge clk);
        req_valid[op.engine] <= 1'b0;
    endtask

    task automatic collect_read(op_t op);
        tma_smem_rsp_t exp;
        int            cycles;
        int            port;
        exp    = expected_rsp(op);
        cycles = 0;
        port   = -1;
        while (port < 0) begin
            @(negedge clk);
            cycles++;
            for (int p = 0; p < `TMA_NUM_UNITS; p++) begin
                if (rsp_valid[p] && port < 0) port = p;
            end
            if (port < 0 && cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timed out waiting for the response to %s", op.name));
            end
        end
        check_engine(op.name, engine_field(exp.tag), engine_id_t'(port));
        check_rsp(op.name, exp, rsp_data[port]);
        check_latency(op.name, READ_LATENCY, cycles);
    endtask

    // All engines read from one socket in the same cycle, optionally with random stalls
    task automatic run_burst(string name, core_id_t core, uuid_t uuid_base, bit stall);
        logic [`TMA_NUM_UNITS-1:0] fired;
        logic [`TMA_NUM_UNITS-1:0] got;
        tma_smem_rsp_t             exp [`TMA_NUM_UNITS];
        op_t                       op;
        int                        cycles;
        got    = '0;
        cycles = 0;
        @(posedge clk);
        for (int e = 0; e < `TMA_NUM_UNITS; e++) begin
            op = make_op(name, engine_id_t'(e), 1'b0, core, smem_addr_t'(BURST_ADDR + e),
                         '0, '0, uuid_t'(uuid_base + e));
            exp[e] = expected_rsp(op);
            req_valid[e] <= 1'b1;
            req_data[e]  <= make_req(op);
        end
        while (got != '1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timed out in %s with %0d of %0d responses received",
                                    name, $countones(got), `TMA_NUM_UNITS));
            end
            fired = req_valid & req_ready;
            for (int p = 0; p < `TMA_NUM_UNITS; p++) begin
                if (rsp_valid[p] && rsp_ready[p]) begin
                    if (got[p]) begin
                        abort_run($sformatf("Engine %0d got a second response in %s", p, name));
                    end
                    check_engine(name, engine_id_t'(p), engine_field(rsp_data[p].tag));
                    check_rsp(name, exp[p], rsp_data[p]);
                    got[p] = 1'b1;
                end
            end
            @(posedge clk);
            for (int e = 0; e < `TMA_NUM_UNITS; e++) begin
                if (fired[e]) req_valid[e] <= 1'b0;
                if (stall) rsp_ready[e] <= ($urandom_range(0, 2) != 0);
            end
        end
        rsp_ready <= '1;
        // Nothing more may show up once every engine has its answer
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check_ports({name, "_quiet"}, '0, rsp_valid);
        end
    endtask

    initial begin
        void'($urandom(93));
        rst_n     <= 1'b0;
        req_valid <= '0;
        req_data  <= '0;
        rsp_ready <= '1;

        // Name, engine, rw, core, address, data, byte enables, uuid
        ops.push_back(make_op("full_write", 2'd0, 1'b1, 2'd1, 8'h20, 32'hDEAD_BEEF, 4'hF, 4'h1));
        ops.push_back(make_op("full_read", 2'd0, 1'b0, 2'd1, 8'h20, 32'h0, 4'h0, 4'h2));
        ops.push_back(make_op("partial_write", 2'd1, 1'b1, 2'd1, 8'h20, 32'h1122_3344, 4'h5, 4'h3));
        ops.push_back(make_op("partial_read", 2'd1, 1'b0, 2'd0, 8'h20, 32'h0, 4'h0, 4'h4));
        ops.push_back(make_op("core0_write", 2'd2, 1'b1, 2'd0, 8'h40, 32'hA5A5_0000, 4'hF, 4'h5));
        ops.push_back(make_op("core2_write", 2'd3, 1'b1, 2'd2, 8'h40, 32'h0000_5A5A, 4'hF, 4'h6));
        ops.push_back(make_op("core0_read", 2'd3, 1'b0, 2'd0, 8'h40, 32'h0, 4'h0, 4'h7));
        ops.push_back(make_op("core2_read", 2'd2, 1'b0, 2'd2, 8'h40, 32'h0, 4'h0, 4'h8));
        for (int e = 0; e < `TMA_NUM_UNITS; e++) begin
            ops.push_back(make_op("burst_init", engine_id_t'(e), 1'b1, 2'd2,
                                  smem_addr_t'(BURST_ADDR + e), 32'hC0DE_0000 + e * 32'h1111,
                                  4'hF, 4'h9));
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ports("reset_rsp_valid", '0, rsp_valid);
        check_ports("reset_req_ready", '1, req_ready);

        foreach (ops[i]) begin
            send_op(ops[i]);
            if (ops[i].rw) begin
                model_write(ops[i]);
            end else begin
                collect_read(ops[i]);
            end
        end

        run_burst("burst_all_ready", 2'd2, 4'h8, 1'b0);
        run_burst("burst_backpressure", 2'd3, 4'hC, 1'b1);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
hw/tma_route_pkg.sv
hw/tma_smem_pkg.sv
hw/tma_stream_xbar.sv
hw/tma_cluster_smem_xbar.sv
hw/socket_smem.sv
hw/tma_smem_subsystem_top.sv
verification/tma_smem_tb.sv

// ==== Bender.yml ====
package:
  name: tma_smem_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/tma_route_pkg.sv
      - hw/tma_smem_pkg.sv
      - hw/tma_stream_xbar.sv
      - hw/tma_cluster_smem_xbar.sv
      - hw/socket_smem.sv
      - hw/tma_smem_subsystem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tma_smem_tb.sv
